// File: Makefile
# Verilator build for the memory access testbench

VERILATOR ?= verilator
FILELIST  ?= proc_mem_arbiter.f
TB_TOP    ?= proc_mem_tb
RTL_TOP   ?= proc_mem_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?=

SIM_BIN = $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(SIM_BIN): $(FILELIST) $(wildcard design/*.sv) $(wildcard dv/*.sv) $(wildcard include/*.svh)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

// File: design/data_port.sv
/*
 * core-side data port
 * holds one load or store on the bus until accepted, returns load data
 */

`timescale 1ns/1ps
`include "proc_mem_params.svh"

module data_port (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         dmem_load,
    input  logic                         dmem_store,
    input  logic [`XLEN-1:0]             dmem_addr,
    input  logic [`MEM_WIDTH-1:0]        dmem_wdata,
    output logic                         req,
    output proc_mem_pkg::bus_command_t   req_command,
    output logic [`XLEN-1:0]             req_addr,
    output logic [`MEM_WIDTH-1:0]        req_data,
    input  logic                         accepted,
    input  logic                         reply,
    input  proc_mem_pkg::mem_word_u      reply_data,
    output logic                         dmem_busy,
    output logic                         dmem_load_done,
    output logic [`MEM_WIDTH-1:0]        dmem_rdata,
    output logic                         dmem_store_done
);

    import proc_mem_pkg::*;

    // fsm encodings
    localparam logic [1:0] state_idle    = 2'd0;
    localparam logic [1:0] state_request = 2'd1;
    localparam logic [1:0] state_wait    = 2'd2;

    logic [1:0]            state;
    bus_command_t          cmd_q;
    logic [`XLEN-1:0]      addr_q;
    logic [`MEM_WIDTH-1:0] wdata_q;

    //////////////////////////////
    // bus request
    //////////////////////////////

    // latched request stays on the bus until accepted
    assign req         = (state == state_request);
    assign req_command = cmd_q;
    assign req_addr    = addr_q;
    assign req_data    = wdata_q;

    // busy covers request and load wait
    assign dmem_busy = (state != state_idle);

    //////////////////////////////
    // control
    //////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state           <= state_idle;
            cmd_q           <= bus_none;
            dmem_load_done  <= 1'b0;
            dmem_store_done <= 1'b0;
        end else begin
            dmem_load_done  <= 1'b0;
            dmem_store_done <= 1'b0;
            case (state)
                state_idle: begin
                    if (dmem_load || dmem_store) begin
                        state <= state_request;
                        cmd_q <= dmem_load ? bus_load : bus_store;
                    end
                end
                state_request: begin
                    if (accepted) begin
                        // a store is finished once memory takes it
                        if (cmd_q == bus_load) begin
                            state <= state_wait;
                        end else begin
                            state           <= state_idle;
                            dmem_store_done <= 1'b1;
                        end
                    end
                end
                state_wait: begin
                    if (reply) begin
                        state          <= state_idle;
                        dmem_load_done <= 1'b1;
                    end
                end
                default: state <= state_idle;
            endcase
        end
    end

    //////////////////////////////
    // payload
    //////////////////////////////

    // address and store data from the strobe cycle
    always_ff @(posedge clock) begin
        if ((state == state_idle) && (dmem_load || dmem_store)) begin
            addr_q  <= dmem_addr;
            wdata_q <= dmem_wdata;
        end
    end

    // full doubleword goes back to the core
    always_ff @(posedge clock) begin
        if (reply && (state == state_wait)) begin
            dmem_rdata <= reply_data.dword;
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    assert property (@(posedge clock) disable iff (reset)
        (dmem_load || dmem_store) |-> !dmem_busy)
        else $error("data strobe while port busy");

    assert property (@(posedge clock) disable iff (reset)
        !(dmem_load && dmem_store))
        else $error("load and store strobed together");

    // reply must belong to our pending load
    assert property (@(posedge clock) disable iff (reset)
        reply |-> (state == state_wait))
        else $error("data reply outside load wait");

endmodule

// File: design/fetch_unit.sv
/*
 * sequential instruction fetcher
 * one outstanding doubleword read, picks the 32-bit half for the pc
 */

`timescale 1ns/1ps
`include "proc_mem_params.svh"

module fetch_unit (
    input  logic                     clock,
    input  logic                     reset,
    output logic                     req,
    output logic [`XLEN-1:0]         req_addr,
    input  logic                     accepted,
    input  logic                     reply,
    input  proc_mem_pkg::mem_word_u  reply_data,
    output logic                     fetch_valid,
    output logic [`XLEN-1:0]         fetch_pc,
    output logic [`XLEN-1:0]         fetch_inst
);

    import proc_mem_pkg::*;

    // fsm encodings
    localparam logic state_request = 1'b0;
    localparam logic state_wait    = 1'b1;

    logic             state;
    logic             run;
    logic [`XLEN-1:0] pc;

    //////////////////////////////
    // bus request
    //////////////////////////////

    // held level until the arbiter accepts it
    assign req      = run && (state == state_request);
    // doubleword aligned read
    assign req_addr = {pc[`XLEN-1:3], 3'b000};

    //////////////////////////////
    // control
    //////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state       <= state_request;
            run         <= 1'b0;
            pc          <= `RESET_PC;
            fetch_valid <= 1'b0;
        end else begin
            // first request goes out one cycle after reset releases
            run         <= 1'b1;
            fetch_valid <= 1'b0;
            case (state)
                state_request: begin
                    if (accepted) begin
                        state <= state_wait;
                    end
                end
                state_wait: begin
                    // reply closes the read, step to next word
                    if (reply) begin
                        state       <= state_request;
                        fetch_valid <= 1'b1;
                        pc          <= pc + `XLEN'd4;
                    end
                end
                default: state <= state_request;
            endcase
        end
    end

    //////////////////////////////
    // instruction capture
    //////////////////////////////

    // pc bit 2 picks the half within the doubleword
    always_ff @(posedge clock) begin
        if (reply && (state == state_wait)) begin
            fetch_pc   <= pc;
            fetch_inst <= reply_data.inst[pc[2]];
        end
    end

    // reply only after an accepted read
    assert property (@(posedge clock) disable iff (reset)
        reply |-> (state == state_wait))
        else $error("fetch reply arrived while still requesting");

endmodule

// File: design/mem_arbiter.sv
/*
 * memory bus arbiter, data port ahead of fetch
 * records the owner of each accepted load tag and routes replies back
 */

`timescale 1ns/1ps
`include "proc_mem_params.svh"

module mem_arbiter (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         fetch_req,
    input  logic [`XLEN-1:0]             fetch_addr,
    input  logic                         data_req,
    input  proc_mem_pkg::bus_command_t   data_command,
    input  logic [`XLEN-1:0]             data_addr,
    input  logic [`MEM_WIDTH-1:0]        data_data,
    output logic                         fetch_accepted,
    output logic                         fetch_reply,
    output logic                         data_accepted,
    output logic                         data_reply,
    output proc_mem_pkg::mem_word_u      reply_data,
    output proc_mem_pkg::bus_command_t   proc2mem_command,
    output logic [`XLEN-1:0]             proc2mem_addr,
    output logic [`MEM_WIDTH-1:0]        proc2mem_data,
    input  logic [`TAG_BITS-1:0]         mem2proc_response,
    input  logic [`TAG_BITS-1:0]         mem2proc_tag,
    input  logic [`MEM_WIDTH-1:0]        mem2proc_data
);

    import proc_mem_pkg::*;

    // per-tag owner and outstanding flag
    owner_t             owner_table [`NUM_TAGS];
    logic [`NUM_TAGS-1:0] tag_busy;

    logic   grant_fetch;
    logic   response_ok;
    logic   record_en;
    owner_t record_owner;
    logic   reply_hit;

    //////////////////////////////
    // grant and bus drive
    //////////////////////////////

    // data wins whenever it asks
    assign grant_fetch = fetch_req && !data_req;

    always_comb begin
        proc2mem_command = bus_none;
        proc2mem_addr    = fetch_addr;
        proc2mem_data    = '0;
        if (data_req) begin
            proc2mem_command = data_command;
            proc2mem_addr    = data_addr;
            proc2mem_data    = data_data;
        end else if (fetch_req) begin
            // fetches are always loads
            proc2mem_command = bus_load;
        end
    end

    // nonzero response means memory took the command
    assign response_ok    = (mem2proc_response != '0);
    assign data_accepted  = data_req && response_ok;
    assign fetch_accepted = grant_fetch && response_ok;

    //////////////////////////////
    // owner table
    //////////////////////////////

    // only loads get a reply, stores end here
    assign record_en    = fetch_accepted || (data_accepted && (data_command == bus_load));
    assign record_owner = data_accepted ? owner_data : owner_fetch;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            tag_busy <= '0;
            for (int i = 0; i < `NUM_TAGS; i++) begin
                owner_table[i] <= owner_fetch;
            end
        end else begin
            // retire first so a reused tag can be claimed again
            if (reply_hit) begin
                tag_busy[mem2proc_tag] <= 1'b0;
            end
            if (record_en) begin
                tag_busy[mem2proc_response]    <= 1'b1;
                owner_table[mem2proc_response] <= record_owner;
            end
        end
    end

    //////////////////////////////
    // reply routing
    //////////////////////////////

    assign reply_hit   = (mem2proc_tag != '0) && tag_busy[mem2proc_tag];
    assign fetch_reply = reply_hit && (owner_table[mem2proc_tag] == owner_fetch);
    assign data_reply  = reply_hit && (owner_table[mem2proc_tag] == owner_data);

    // both requesters read the same word, each in its own view
    assign reply_data = mem2proc_data;

    //////////////////////////////
    // checks
    //////////////////////////////

    // every reply tag was handed out earlier and is still open
    assert property (@(posedge clock) disable iff (reset)
        (mem2proc_tag != '0) |-> tag_busy[mem2proc_tag])
        else $error("reply tag %0h not outstanding", mem2proc_tag);

endmodule

// File: design/proc_mem_pkg.sv
/*
 * shared types for the memory access path
 * bus commands, per-tag owner and the two views of a memory word
 */

`include "proc_mem_params.svh"

package proc_mem_pkg;

    //////////////////////////////
    // bus command
    //////////////////////////////

    // encoding follows the memory protocol
    typedef enum logic [1:0] {
        bus_none  = 2'h0,
        bus_load  = 2'h1,
        bus_store = 2'h2
    } bus_command_t;

    //////////////////////////////
    // tag owner
    //////////////////////////////

    // who issued the load behind a tag
    typedef enum logic {
        owner_fetch = 1'b0,
        owner_data  = 1'b1
    } owner_t;

    //////////////////////////////
    // memory word
    //////////////////////////////

    // data port sees one doubleword
    // fetcher sees two instructions, inst[0] at the lower address
    typedef union packed {
        logic [`MEM_WIDTH-1:0]   dword;
        logic [1:0][`XLEN-1:0]   inst;
    } mem_word_u;

endpackage

// File: design/proc_mem_top.sv
/*
 * memory access top level
 * fetcher and data port share one tagged memory bus through the arbiter
 */

`timescale 1ns/1ps
`include "proc_mem_params.svh"

module proc_mem_top (
    input  logic                         clock,
    input  logic                         reset,

    // memory bus
    output proc_mem_pkg::bus_command_t   proc2mem_command,
    output logic [`XLEN-1:0]             proc2mem_addr,
    output logic [`MEM_WIDTH-1:0]        proc2mem_data,
    input  logic [`TAG_BITS-1:0]         mem2proc_response,
    input  logic [`MEM_WIDTH-1:0]        mem2proc_data,
    input  logic [`TAG_BITS-1:0]         mem2proc_tag,

    // core data side
    input  logic                         dmem_load,
    input  logic                         dmem_store,
    input  logic [`XLEN-1:0]             dmem_addr,
    input  logic [`MEM_WIDTH-1:0]        dmem_wdata,
    output logic                         dmem_busy,
    output logic                         dmem_load_done,
    output logic [`MEM_WIDTH-1:0]        dmem_rdata,
    output logic                         dmem_store_done,

    // core fetch side
    output logic                         fetch_valid,
    output logic [`XLEN-1:0]             fetch_pc,
    output logic [`XLEN-1:0]             fetch_inst
);

    import proc_mem_pkg::*;

    //////////////////////////////
    // requester wires
    //////////////////////////////

    logic                  fetch_req;
    logic [`XLEN-1:0]      fetch_addr;
    logic                  fetch_accepted;
    logic                  fetch_reply;

    logic                  data_req;
    bus_command_t          data_command;
    logic [`XLEN-1:0]      data_addr;
    logic [`MEM_WIDTH-1:0] data_data;
    logic                  data_accepted;
    logic                  data_reply;

    // shared reply word, fanned out to both
    mem_word_u             reply_data;

    //////////////////////////////
    // instances
    //////////////////////////////

    fetch_unit u_fetch (
        .clock       (clock),
        .reset       (reset),
        .req         (fetch_req),
        .req_addr    (fetch_addr),
        .accepted    (fetch_accepted),
        .reply       (fetch_reply),
        .reply_data  (reply_data),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_inst  (fetch_inst)
    );

    data_port u_data (
        .clock           (clock),
        .reset           (reset),
        .dmem_load       (dmem_load),
        .dmem_store      (dmem_store),
        .dmem_addr       (dmem_addr),
        .dmem_wdata      (dmem_wdata),
        .req             (data_req),
        .req_command     (data_command),
        .req_addr        (data_addr),
        .req_data        (data_data),
        .accepted        (data_accepted),
        .reply           (data_reply),
        .reply_data      (reply_data),
        .dmem_busy       (dmem_busy),
        .dmem_load_done  (dmem_load_done),
        .dmem_rdata      (dmem_rdata),
        .dmem_store_done (dmem_store_done)
    );

    mem_arbiter u_arbiter (
        .clock             (clock),
        .reset             (reset),
        .fetch_req         (fetch_req),
        .fetch_addr        (fetch_addr),
        .data_req          (data_req),
        .data_command      (data_command),
        .data_addr         (data_addr),
        .data_data         (data_data),
        .fetch_accepted    (fetch_accepted),
        .fetch_reply       (fetch_reply),
        .data_accepted     (data_accepted),
        .data_reply        (data_reply),
        .reply_data        (reply_data),
        .proc2mem_command  (proc2mem_command),
        .proc2mem_addr     (proc2mem_addr),
        .proc2mem_data     (proc2mem_data),
        .mem2proc_response (mem2proc_response),
        .mem2proc_tag      (mem2proc_tag),
        .mem2proc_data     (mem2proc_data)
    );

endmodule

// File: dv/proc_mem_tb.sv
/*
 * testbench for the memory access top level
 * tagged memory model with rejects and random latency, core data stimulus
 */

`timescale 1ns/1ps
`include "proc_mem_params.svh"

module proc_mem_tb;

    import proc_mem_pkg::*;

    localparam logic [`XLEN-1:0] fill_pattern = 32'h5a3c_96e1;
    localparam logic [`XLEN-1:0] data_base    = 32'h0000_8000;

    logic                  clock;
    logic                  reset;
    logic                  dmem_load;
    logic                  dmem_store;
    logic [`XLEN-1:0]      dmem_addr;
    logic [`MEM_WIDTH-1:0] dmem_wdata;
    logic [`TAG_BITS-1:0]  mem2proc_response;
    logic [`MEM_WIDTH-1:0] mem2proc_data;
    logic [`TAG_BITS-1:0]  mem2proc_tag;
    bus_command_t          proc2mem_command;
    logic [`XLEN-1:0]      proc2mem_addr;
    logic [`MEM_WIDTH-1:0] proc2mem_data;
    logic                  dmem_busy;
    logic                  dmem_load_done;
    logic [`MEM_WIDTH-1:0] dmem_rdata;
    logic                  dmem_store_done;
    logic                  fetch_valid;
    logic [`XLEN-1:0]      fetch_pc;
    logic [`XLEN-1:0]      fetch_inst;

    integer seed = 32'h911732c6;

    // memory model state
    logic [`MEM_WIDTH-1:0] mem [logic [`XLEN-1:0]];
    logic [`TAG_BITS-1:0]  pend_tag [$];
    logic [`MEM_WIDTH-1:0] pend_data [$];
    int                    pend_due [$];
    int                    cycle;
    logic                  reject;
    logic                  advance_tag;
    logic [`TAG_BITS-1:0]  next_tag;

    // expected values
    logic [`XLEN-1:0]      exp_pc;
    logic [`XLEN-1:0]      exp_inst;
    int                    fetch_count;
    bus_command_t          exp_data_cmd;
    logic [`XLEN-1:0]      exp_data_addr;
    logic [`MEM_WIDTH-1:0] exp_store_data;
    logic [`MEM_WIDTH-1:0] exp_load_data;

    proc_mem_top u_dut (.*);

    ///////////////////////////////
    // helpers
    ///////////////////////////////

    // unwritten words hold address xor pattern, per half
    function automatic logic [`MEM_WIDTH-1:0] mem_read(input logic [`XLEN-1:0] addr);
        logic [`XLEN-1:0] base;
        base = {addr[`XLEN-1:3], 3'b000};
        if (mem.exists(base)) begin
            return mem[base];
        end
        return {(base | 32'h4) ^ fill_pattern, base ^ fill_pattern};
    endfunction

    function automatic logic [`XLEN-1:0] inst_at(input logic [`XLEN-1:0] addr);
        logic [`MEM_WIDTH-1:0] word;
        word = mem_read(addr);
        return addr[2] ? word[63:32] : word[31:0];
    endfunction

    task automatic value_mismatch(input string name, input logic [63:0] expected,
                                  input logic [63:0] actual);
        $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        $display("test failed");
        $fatal(1, "value mismatch on %s", name);
    endtask

    task automatic run_aborted(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "run aborted");
    endtask

    ///////////////////////////////
    // clock
    ///////////////////////////////

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    ///////////////////////////////
    // memory model
    ///////////////////////////////

    // same-cycle response, tag unless rejected
    assign mem2proc_response = (proc2mem_command != bus_none && !reject) ? next_tag : '0;

    // bus values are settled at the falling edge
    always @(negedge clock) begin
        if (proc2mem_command != bus_none && mem2proc_response != '0) begin
            advance_tag = 1'b1;
            if (proc2mem_command == bus_store) begin
                mem[{proc2mem_addr[`XLEN-1:3], 3'b000}] = proc2mem_data;
            end else begin
                pend_tag.push_back(mem2proc_response);
                pend_data.push_back(mem_read(proc2mem_addr));
                pend_due.push_back(cycle + 1 + ($unsigned($random(seed)) % 8));
            end
        end
    end

    // replies and reject choice just after the rising edge
    always begin
        @(posedge clock);
        #1;
        cycle = cycle + 1;
        reject = (($random(seed) & 3) == 0);
        if (advance_tag) begin
            next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
            advance_tag = 1'b0;
        end
        mem2proc_tag = '0;
        mem2proc_data = '0;
        for (int i = 0; i < pend_due.size(); i++) begin
            if (pend_due[i] <= cycle) begin
                mem2proc_tag = pend_tag[i];
                mem2proc_data = pend_data[i];
                pend_tag.delete(i);
                pend_data.delete(i);
                pend_due.delete(i);
                break;
            end
        end
    end

    // fetch expectation follows the pc sequence
    always @(posedge clock) begin
        if (reset) begin
            exp_pc      <= `RESET_PC;
            exp_inst    <= inst_at(`RESET_PC);
            fetch_count <= 0;
        end else if (fetch_valid) begin
            exp_pc      <= exp_pc + 32'd4;
            exp_inst    <= inst_at(exp_pc + 32'd4);
            fetch_count <= fetch_count + 1;
        end
    end

    ///////////////////////////////
    // checks
    ///////////////////////////////

    assert property (@(posedge clock) (reset || $past(reset)) |->
        (proc2mem_command == bus_none && !fetch_valid && !dmem_busy
         && !dmem_load_done && !dmem_store_done))
        else run_aborted("outputs active during or right after reset");

    assert property (@(posedge clock) disable iff (reset) fetch_valid |-> fetch_pc == exp_pc)
        else value_mismatch("fetch_pc", 64'(exp_pc), 64'($sampled(fetch_pc)));

    assert property (@(posedge clock) disable iff (reset) fetch_valid |-> fetch_inst == exp_inst)
        else value_mismatch("fetch_inst", 64'(exp_inst), 64'($sampled(fetch_inst)));

    assert property (@(posedge clock) disable iff (reset)
        dmem_load_done |-> dmem_rdata == exp_load_data)
        else value_mismatch("dmem_rdata", exp_load_data, $sampled(dmem_rdata));

    // pending data request owns the bus
    assert property (@(posedge clock) disable iff (reset)
        u_dut.data_req |-> proc2mem_addr == exp_data_addr)
        else value_mismatch("proc2mem_addr", 64'(exp_data_addr), 64'($sampled(proc2mem_addr)));

    assert property (@(posedge clock) disable iff (reset)
        u_dut.data_req |-> proc2mem_command == exp_data_cmd)
        else value_mismatch("proc2mem_command", 64'(exp_data_cmd),
                            64'($sampled(proc2mem_command)));

    // store data reaches the bus as the core drove it
    assert property (@(posedge clock) disable iff (reset)
        (u_dut.data_req && exp_data_cmd == bus_store) |-> proc2mem_data == exp_store_data)
        else value_mismatch("proc2mem_data", exp_store_data, $sampled(proc2mem_data));

    // rejected data command is retried unchanged, with no done pulse
    assert property (@(posedge clock) disable iff (reset)
        (u_dut.data_req && mem2proc_response == '0) |=>
        (u_dut.data_req && proc2mem_command == $past(proc2mem_command)
         && proc2mem_addr == $past(proc2mem_addr) && !dmem_load_done && !dmem_store_done))
        else run_aborted("rejected data command was not retried unchanged");

    // rejected fetch keeps its address and yields no fetch
    assert property (@(posedge clock) disable iff (reset)
        (!u_dut.data_req && proc2mem_command != bus_none && mem2proc_response == '0) |=>
        (u_dut.fetch_req && u_dut.fetch_addr == $past(proc2mem_addr) && !fetch_valid))
        else run_aborted("rejected fetch was not retried unchanged");

    assert property (@(posedge clock) disable iff (reset)
        (u_dut.data_req && proc2mem_command == bus_store && mem2proc_response != '0) |=>
        (dmem_store_done && !dmem_busy))
        else run_aborted("store done did not follow store acceptance by one cycle");

    ///////////////////////////////
    // core stimulus
    ///////////////////////////////

    task automatic data_op(input logic is_load, input logic [`XLEN-1:0] addr,
                           input logic [`MEM_WIDTH-1:0] wdata);
        int waited;
        @(posedge clock);
        #1;
        exp_data_cmd   = is_load ? bus_load : bus_store;
        exp_data_addr  = addr;
        exp_store_data = wdata;
        exp_load_data  = mem_read(addr);
        dmem_load      = is_load;
        dmem_store     = !is_load;
        dmem_addr      = addr;
        dmem_wdata     = wdata;
        @(posedge clock);
        #1;
        dmem_load  = 1'b0;
        dmem_store = 1'b0;
        waited = 0;
        while (!(dmem_load_done || dmem_store_done)) begin
            @(posedge clock);
            #1;
            waited++;
            if (waited > 200) begin
                run_aborted("timeout waiting for data operation to finish");
            end
        end
    endtask

    initial begin
        int waited;
        reset       = 1'b1;
        dmem_load   = 1'b0;
        dmem_store  = 1'b0;
        dmem_addr   = '0;
        dmem_wdata  = '0;
        mem2proc_tag  = '0;
        mem2proc_data = '0;
        reject      = 1'b0;
        advance_tag = 1'b0;
        next_tag    = 4'd1;
        cycle       = 0;
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;
        for (int n = 0; n < 60; n++) begin
            data_op(1'($random(seed)), data_base + (($random(seed) & 7) << 3),
                    {$random(seed), $random(seed)});
        end
        waited = 0;
        while (fetch_count < 300) begin
            @(posedge clock);
            waited++;
            if (waited > 20000) begin
                run_aborted("timeout waiting for 300 fetches");
            end
        end
        $display("test passed");
        $finish;
    end

endmodule

// File: include/proc_mem_params.svh
/*
 * shared width and reset constants for the memory access path
 * fetcher, data port and bus arbiter all size from these
 */

`ifndef PROC_MEM_PARAMS_SVH
`define PROC_MEM_PARAMS_SVH

// address and instruction width
`define XLEN 32

// memory bus data width, one doubleword
`define MEM_WIDTH 64

// response and reply tag width
`define TAG_BITS 4

// owner table depth, one entry per tag
// tag 0 means no transaction
`define NUM_TAGS 16

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// File: proc_mem_arbiter.f
+incdir+include
design/proc_mem_pkg.sv
design/fetch_unit.sv
design/data_port.sv
design/mem_arbiter.sv
design/proc_mem_top.sv
dv/proc_mem_tb.sv
